/* dv/pe_state_regs_tb.sv */
// -----------------------------
// pe state registers testbench
// table of writes, idles and layer sweeps
// checked against a cycle-accurate model
// -----------------------------

`timescale 1ns/1ps

module pe_state_regs_tb;

        import pe_cfg_pkg::*;

        localparam int act_w        = act_w_default;
        localparam int col_w        = col_w_default;
        localparam int wmem_w       = wmem_w_default;
        localparam int reset_cycles = 8;
        localparam int max_steps    = 128;
        localparam int step_write   = 0;
        localparam int step_idle    = 1;
        localparam int step_check   = 2;

        logic                  clk;
        logic                  rst;
        logic                  cfg_wr_en;
        logic [cfg_addr_w-1:0] cfg_wr_addr;
        logic [cfg_data_w-1:0] cfg_wr_data;
        logic [layer_w-1:0]    layer_idx;
        logic [layer_w-1:0]    layer_no;
        logic [act_w-1:0]      in_act_no;
        logic [act_w-1:0]      out_act_no;
        logic [col_w-1:0]      col_dim;
        logic [wmem_w-1:0]     w_mem_offset;
        logic                  in_act_relu;
        logic                  out_act_relu;
        logic [trunc_w-1:0]    act_trunc;

        // ---------------------------
        // step table
        // ---------------------------
        int              step_kind [max_steps];
        logic [6:0]      step_addr [max_steps];
        logic [15:0]     step_data [max_steps];
        int              step_idx  [max_steps];
        string           step_name [max_steps];
        int              n_steps = 0;

        // ---------------------------
        // reference model state
        // ---------------------------
        logic [2:0]        m_layer_no;
        logic [act_w-1:0]  m_act   [0:7];
        logic [col_w-1:0]  m_col   [0:6];
        logic [wmem_w-1:0] m_wmem  [0:6];
        logic [4:0]        m_trunc [0:6];
        logic [8:0]        m_relu;
        logic              drv_v;               // strobe as driven
        logic              dec_v;               // strobe held by decoder
        logic [6:0]        drv_a;
        logic [6:0]        dec_a;
        logic [15:0]       drv_d;
        logic [15:0]       dec_d;

        logic [31:0] lcg_state = 32'h8716_68d1;
        int          cycle_cnt = 0;
        int          timeout_limit = 0;

        pe_state_regs DUT (
                .clk          (clk),
                .rst          (rst),
                .cfg_wr_en    (cfg_wr_en),
                .cfg_wr_addr  (cfg_wr_addr),
                .cfg_wr_data  (cfg_wr_data),
                .layer_idx    (layer_idx),
                .layer_no     (layer_no),
                .in_act_no    (in_act_no),
                .out_act_no   (out_act_no),
                .col_dim      (col_dim),
                .w_mem_offset (w_mem_offset),
                .in_act_relu  (in_act_relu),
                .out_act_relu (out_act_relu),
                .act_trunc    (act_trunc)
        );

        initial begin
                clk = 1'b0;
                forever #50 clk = ~clk;         // 100 ns period
        end

        function automatic logic [31:0] lcg_next(input logic [31:0] s);
                return s * 32'd1664525 + 32'd1013904223;
        endfunction

        task automatic add_step(input int kind, input string name, input logic [6:0] addr,
                                input logic [15:0] data, input int idx);
                step_kind[n_steps] = kind;
                step_name[n_steps] = name;
                step_addr[n_steps] = addr;
                step_data[n_steps] = data;
                step_idx[n_steps]  = idx;
                n_steps++;
        endtask

        task automatic add_rand_write(input string name, input logic [6:0] addr);
                lcg_state = lcg_next(lcg_state);
                add_step(step_write, name, addr, lcg_state[31:16], 0);  // upper half of state
        endtask

        task automatic add_idle(input int n);
                for (int i = 0; i < n; i++) add_step(step_idle, "idle", '0, '0, 0);
        endtask

        task automatic add_sweep(input string name);
                for (int i = 0; i < 8; i++) add_step(step_check, name, '0, '0, i);
        endtask

        // address map and unpacking as the host sees it
        task automatic apply_write(input logic [6:0] a, input logic [15:0] d);
                int k;
                k = (int'(a) % 2 == 0) ? int'(a) / 2 : -1;     // even addresses only
                if (k == 0) m_layer_no = d[2:0];
                else if (k >= 1 && k <= 4) begin
                        m_act[2*(k-1)]   = d[5:0];
                        m_act[2*(k-1)+1] = d[13:8];
                end else if (k >= 5 && k <= 11) m_col[k-5] = d[col_w-1:0];
                else if (k >= 12 && k <= 18) m_wmem[k-12] = d[wmem_w-1:0];
                else if (k == 19) m_relu = d[8:0];
                else if (k >= 20 && k <= 22) begin
                        for (int j = 0; j < 3; j++) begin
                                if (3*(k-20) + j < 7) m_trunc[3*(k-20) + j] = d[5*j +: 5];
                        end
                end
        endtask

        // per edge the table takes the decoded write and the decoder takes the strobe
        task automatic model_tick(input logic wr, input logic [6:0] a, input logic [15:0] d);
                if (dec_v) apply_write(dec_a, dec_d);
                dec_v = drv_v;
                dec_a = drv_a;
                dec_d = drv_d;
                drv_v = wr;
                drv_a = a;
                drv_d = d;
        endtask

        task automatic check_value(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
                if (expected !== actual) begin
                        $display("Mismatch in %s: expected %0h, actual %0h",
                                 name, expected, actual);
                        $display("Something failed");
                        $fatal(1, "check failed");
                end
        endtask

        task automatic check_outputs(input string name, input int idx);
                string n;
                logic  exp_relu;
                n = $sformatf("%s idx %0d", name, idx);
                exp_relu = (idx == int'(m_layer_no)) ? m_relu[m_layer_no] : m_relu[idx+1];
                check_value({n, " layer_no"}, m_layer_no, layer_no);
                check_value({n, " in_act_no"}, m_act[idx], in_act_no);
                check_value({n, " out_act_no"}, (idx == 7) ? '0 : m_act[idx+1], out_act_no);
                check_value({n, " col_dim"}, (idx == 7) ? '0 : m_col[idx], col_dim);
                check_value({n, " w_mem_offset"}, (idx == 7) ? '0 : m_wmem[idx], w_mem_offset);
                check_value({n, " act_trunc"}, (idx == 7) ? '0 : m_trunc[idx], act_trunc);
                check_value({n, " in_act_relu"}, m_relu[idx], in_act_relu);
                check_value({n, " out_act_relu"}, exp_relu, out_act_relu);
        endtask

        // run limit of twice the table plus reset
        always @(posedge clk) begin
                cycle_cnt <= cycle_cnt + 1;
                if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
                        $display("Timeout: the step table did not finish in %0d cycles",
                                 timeout_limit);
                        $display("Something failed");
                        $fatal(1, "timeout");
                end
        end

        initial begin
                rst         = 1'b1;
                cfg_wr_en   = 1'b0;
                cfg_wr_addr = '0;
                cfg_wr_data = '0;
                layer_idx   = '0;
                m_layer_no  = '0;
                m_relu      = '0;
                for (int i = 0; i < 8; i++) m_act[i] = '0;
                for (int i = 0; i < 7; i++) begin
                        m_col[i]   = '0;
                        m_wmem[i]  = '0;
                        m_trunc[i] = '0;
                end
                {drv_v, dec_v, drv_a, dec_a, drv_d, dec_d} = '0;

                // ---------------------------
                // build the step table
                // ---------------------------
                add_sweep("reset");
                for (int a = 0; a <= 44; a += 2) add_rand_write("config", 7'(a)); // whole map
                add_idle(2);
                add_sweep("config");
                add_step(step_write, "relu rule", 7'd0, 16'h0003, 0);   // layer_no 3
                add_step(step_write, "relu rule", 7'd38, 16'h0008, 0);  // bit 3 on and bit 4 off
                add_idle(2);
                add_step(step_check, "relu rule", '0, '0, 3);
                add_step(step_check, "relu rule", '0, '0, 2);
                add_step(step_check, "relu rule", '0, '0, 4);
                add_rand_write("unmapped", 7'd1);
                add_rand_write("unmapped", 7'd3);
                add_rand_write("unmapped", 7'd39);
                add_rand_write("unmapped", 7'd46);
                add_rand_write("unmapped", 7'd64);
                add_rand_write("unmapped", 7'd127);
                add_idle(2);
                add_sweep("unmapped");
                for (int i = 0; i < 3; i++) add_rand_write("back to back", 7'd10); // last wins
                add_rand_write("back to back", 7'd12);
                add_rand_write("back to back", 7'd24);
                add_rand_write("back to back", 7'd2);
                add_idle(2);
                add_sweep("back to back");
                add_step(step_write, "wide data", 7'd0, 16'hfffd, 0);   // layer_no 5
                add_step(step_write, "wide data", 7'd12, 16'hab5c, 0);  // col_dim 1 = 5c
                add_idle(2);
                add_sweep("wide data");
                timeout_limit = 2 * n_steps + reset_cycles;

                repeat (reset_cycles) @(posedge clk);
                rst <= 1'b0;

                // ---------------------------
                // apply the table
                // ---------------------------
                for (int s = 0; s < n_steps; s++) begin
                        @(posedge clk);
                        model_tick(step_kind[s] == step_write, step_addr[s], step_data[s]);
                        cfg_wr_en   <= (step_kind[s] == step_write);
                        cfg_wr_addr <= step_addr[s];
                        cfg_wr_data <= step_data[s];
                        if (step_kind[s] == step_check) begin
                                layer_idx <= 3'(step_idx[s]);
                                @(negedge clk);         // outputs settled mid-cycle
                                check_outputs(step_name[s], step_idx[s]);
                        end
                end

                $display("Everything OK");
                $finish;
        end

endmodule

/* flist.f */
hw/pe_cfg_pkg.sv
hw/cfg_write_decoder.sv
hw/layer_param_table.sv
hw/layer_param_select.sv
hw/pe_state_regs.sv
dv/pe_state_regs_tb.sv

/* hw/cfg_write_decoder.sv */
// -----------------------------
// config write decoder
// registers each host write and classifies
// its address into field kind and slot
// -----------------------------

`timescale 1ns/1ps

module cfg_write_decoder (
        input  logic                              clk,
        input  logic                              rst,
        input  logic                              wr_en,   // one-cycle strobe
        input  logic [pe_cfg_pkg::cfg_addr_w-1:0] wr_addr,
        input  logic [pe_cfg_pkg::cfg_data_w-1:0] wr_data,
        output pe_cfg_pkg::cfg_field_e            field,   // fld_none = idle
        output logic [pe_cfg_pkg::layer_w-1:0]    slot,    // base register index
        output logic [pe_cfg_pkg::cfg_data_w-1:0] data
);

        import pe_cfg_pkg::*;

        // ---------------------------
        // address offsets per region
        // ---------------------------
        logic [cfg_addr_w-1:0] act_off;
        logic [cfg_addr_w-1:0] col_off;
        logic [cfg_addr_w-1:0] wmem_off;
        logic [cfg_addr_w-1:0] trunc_off;

        cfg_field_e            fld_d;   // next field kind
        logic [layer_w-1:0]    slot_d;  // next slot

        assign act_off   = wr_addr - addr_act_base;
        assign col_off   = wr_addr - addr_col_base;
        assign wmem_off  = wr_addr - addr_wmem_base;
        assign trunc_off = wr_addr - addr_trunc_base;

        // ---------------------------
        // classify
        // ---------------------------
        always_comb begin
                fld_d  = fld_none;
                slot_d = '0;
                // odd addresses never map
                if (wr_en && !wr_addr[0]) begin
                        if (wr_addr == addr_layer_no) begin
                                fld_d = fld_layer_no;
                        end else if (wr_addr >= addr_act_base &&
                                     wr_addr <= addr_act_last) begin
                                // pair k -> slots 2k, 2k+1, offset is already 2k
                                fld_d  = fld_act_pair;
                                slot_d = act_off[layer_w-1:0];
                        end else if (wr_addr >= addr_col_base &&
                                     wr_addr <= addr_col_last) begin
                                fld_d  = fld_col_dim;
                                slot_d = col_off[layer_w:1]; // one slot per 2 addrs
                        end else if (wr_addr >= addr_wmem_base &&
                                     wr_addr <= addr_wmem_last) begin
                                fld_d  = fld_wmem_off;
                                slot_d = wmem_off[layer_w:1];
                        end else if (wr_addr == addr_relu) begin
                                fld_d = fld_relu;
                        end else if (wr_addr >= addr_trunc_base &&
                                     wr_addr <= addr_trunc_last) begin
                                // group k -> slot 3k, built as 2k + k
                                fld_d  = fld_trunc3;
                                slot_d = trunc_off[layer_w-1:0] +
                                         {1'b0, trunc_off[layer_w-1:1]};
                        end
                end
        end

        // ---------------------------
        // decode stage register
        // ---------------------------
        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        field <= fld_none;
                        slot  <= '0;
                        data  <= '0;
                end else begin
                        field <= fld_d;         // taken every cycle, no stall
                        slot  <= slot_d;
                        data  <= wr_data;
                end
        end

endmodule

/* hw/layer_param_select.sv */
// -----------------------------
// layer readout selector
// picks current layer's parameters,
// last-layer rule for output relu
// -----------------------------

`timescale 1ns/1ps

module layer_param_select #(
        parameter int act_w  = pe_cfg_pkg::act_w_default,
        parameter int col_w  = pe_cfg_pkg::col_w_default,
        parameter int wmem_w = pe_cfg_pkg::wmem_w_default
) (
        input  logic [pe_cfg_pkg::layer_w-1:0]    layer_no_q,
        input  logic [pe_cfg_pkg::max_layers-1:0][act_w-1:0]  act_no_q,
        input  logic [pe_cfg_pkg::param_slots-1:0][col_w-1:0] col_dim_q,
        input  logic [pe_cfg_pkg::param_slots-1:0][wmem_w-1:0] wmem_off_q,
        input  logic [pe_cfg_pkg::max_layers:0]   relu_en_q,
        input  logic [pe_cfg_pkg::param_slots-1:0][pe_cfg_pkg::trunc_w-1:0] trunc_q,
        input  logic [pe_cfg_pkg::layer_w-1:0]    layer_idx,

        output logic [pe_cfg_pkg::layer_w-1:0]    layer_no,
        output logic [act_w-1:0]                  in_act_no,
        output logic [act_w-1:0]                  out_act_no,
        output logic [col_w-1:0]                  col_dim,
        output logic [wmem_w-1:0]                 w_mem_offset,
        output logic                              in_act_relu,
        output logic                              out_act_relu,
        output logic [pe_cfg_pkg::trunc_w-1:0]    act_trunc
);

        import pe_cfg_pkg::*;

        logic               last_slot;  // layer_idx 7, no per-layer slot
        logic [layer_w-1:0] idx_nxt;    // wraps at 7, masked by last_slot
        logic [layer_w:0]   relu_nxt;   // reaches bit 8

        assign last_slot = (layer_idx == layer_w'(max_layers - 1));
        assign idx_nxt   = layer_idx + 1'b1;
        assign relu_nxt  = {1'b0, layer_idx} + 1'b1;

        assign layer_no     = layer_no_q;
        assign in_act_no    = act_no_q[layer_idx];
        assign out_act_no   = last_slot ? '0 : act_no_q[idx_nxt];
        assign col_dim      = last_slot ? '0 : col_dim_q[layer_idx];
        assign w_mem_offset = last_slot ? '0 : wmem_off_q[layer_idx];
        assign act_trunc    = last_slot ? '0 : trunc_q[layer_idx];

        assign in_act_relu  = relu_en_q[layer_idx];
        // on the final layer the output relu is that layer's own bit
        assign out_act_relu = (layer_idx == layer_no_q) ? relu_en_q[layer_no_q]
                                                        : relu_en_q[relu_nxt];

endmodule

/* hw/layer_param_table.sv */
// -----------------------------
// per-layer parameter table
// holds layer count, act counts, col dims,
// weight offsets, relu bits, trunc codes
// -----------------------------

`timescale 1ns/1ps

module layer_param_table #(
        parameter int act_w  = pe_cfg_pkg::act_w_default,
        parameter int col_w  = pe_cfg_pkg::col_w_default,
        parameter int wmem_w = pe_cfg_pkg::wmem_w_default
) (
        input  logic                              clk,
        input  logic                              rst,

        // decoded write stage
        input  pe_cfg_pkg::cfg_field_e            field,
        input  logic [pe_cfg_pkg::layer_w-1:0]    slot,
        input  logic [pe_cfg_pkg::cfg_data_w-1:0] data,

        // full arrays out
        output logic [pe_cfg_pkg::layer_w-1:0]    layer_no_q,
        output logic [pe_cfg_pkg::max_layers-1:0][act_w-1:0]
                                                  act_no_q,   // one per layer
        output logic [pe_cfg_pkg::param_slots-1:0][col_w-1:0]
                                                  col_dim_q,
        output logic [pe_cfg_pkg::param_slots-1:0][wmem_w-1:0]
                                                  wmem_off_q,
        output logic [pe_cfg_pkg::max_layers:0]   relu_en_q,  // one past last layer
        output logic [pe_cfg_pkg::param_slots-1:0][pe_cfg_pkg::trunc_w-1:0]
                                                  trunc_q
);

        import pe_cfg_pkg::*;

        // odd neighbour of an act pair
        logic [layer_w-1:0] slot_hi;

        assign slot_hi = slot + 1'b1;

        // ---------------------------
        // layer count and act counts
        // ---------------------------
        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        layer_no_q <= '0;
                        act_no_q   <= '0;
                end else begin
                        if (field == fld_layer_no) begin
                                layer_no_q <= data[layer_w-1:0];   // upper bits dropped
                        end
                        if (field == fld_act_pair) begin
                                act_no_q[slot]    <= data[act_w-1:0];
                                act_no_q[slot_hi] <= data[act_hi_lsb +: act_w];
                        end
                end
        end

        // ---------------------------
        // col dim and weight offset
        // ---------------------------
        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        col_dim_q  <= '0;
                        wmem_off_q <= '0;
                end else begin
                        // decoder never hands out slot 7 here
                        if (field == fld_col_dim) begin
                                col_dim_q[slot] <= data[col_w-1:0];
                        end
                        if (field == fld_wmem_off) begin
                                wmem_off_q[slot] <= data[wmem_w-1:0];
                        end
                end
        end

        // ---------------------------
        // relu enables
        // ---------------------------
        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        relu_en_q <= '0;
                end else if (field == fld_relu) begin
                        relu_en_q <= data[max_layers:0];  // 9 bits, whole vector
                end
        end

        // ---------------------------
        // truncation codes
        // ---------------------------
        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        trunc_q <= '0;
                end else if (field == fld_trunc3) begin
                        // last group only lands in slot 6
                        for (int j = 0; j < trunc_per_grp; j++) begin
                                if (int'(slot) + j < param_slots) begin
                                        trunc_q[int'(slot) + j] <=
                                                data[j*trunc_w +: trunc_w];
                                end
                        end
                end
        end

endmodule

/* hw/pe_cfg_pkg.sv */
// -----------------------------
// pe configuration package
// layer count, bus widths, address map
// and the decoded field kinds
// -----------------------------

package pe_cfg_pkg;

        // ---------------------------
        // layer and bus sizes
        // ---------------------------
        localparam int max_layers = 8;          // layer slots
        localparam int layer_w    = 3;          // layer_no / layer_idx width
        localparam int param_slots = max_layers - 1; // col, wmem, trunc entries

        localparam int cfg_addr_w = 7;          // write address width
        localparam int cfg_data_w = 16;         // write data width

        localparam int trunc_w       = 5;       // one truncation code
        localparam int trunc_per_grp = 3;       // codes per trunc write

        // high act count of a pair sits at this bit
        localparam int act_hi_lsb = 8;

        // default field widths, passed down from the top
        localparam int act_w_default  = 6;
        localparam int col_w_default  = 8;
        localparam int wmem_w_default = 10;

        // ---------------------------
        // address map, even slots only
        // ---------------------------
        localparam logic [cfg_addr_w-1:0] addr_layer_no   = 7'd0;
        localparam logic [cfg_addr_w-1:0] addr_act_base   = 7'd2;  // pairs 2..8
        localparam logic [cfg_addr_w-1:0] addr_act_last   = 7'd8;
        localparam logic [cfg_addr_w-1:0] addr_col_base   = 7'd10; // col_dim 10..22
        localparam logic [cfg_addr_w-1:0] addr_col_last   = 7'd22;
        localparam logic [cfg_addr_w-1:0] addr_wmem_base  = 7'd24; // offsets 24..36
        localparam logic [cfg_addr_w-1:0] addr_wmem_last  = 7'd36;
        localparam logic [cfg_addr_w-1:0] addr_relu       = 7'd38; // relu bits
        localparam logic [cfg_addr_w-1:0] addr_trunc_base = 7'd40; // groups 40..44
        localparam logic [cfg_addr_w-1:0] addr_trunc_last = 7'd44;

        // ---------------------------
        // decoded field kind
        // ---------------------------
        // fld_none doubles as "no write this cycle"
        typedef enum logic [2:0] {
                fld_none,
                fld_layer_no,
                fld_act_pair,   // two act counts
                fld_col_dim,
                fld_wmem_off,
                fld_relu,       // all relu enables at once
                fld_trunc3      // three trunc codes
        } cfg_field_e;

endpackage

/* hw/pe_state_regs.sv */
// -----------------------------
// pe state registers, top level
// host writes per-layer parameters at boot,
// readout follows layer_idx during inference
// -----------------------------

`timescale 1ns/1ps

module pe_state_regs #(
        parameter int act_w  = pe_cfg_pkg::act_w_default,  // act count width
        parameter int col_w  = pe_cfg_pkg::col_w_default,  // column dim width
        parameter int wmem_w = pe_cfg_pkg::wmem_w_default  // weight offset width
) (
        input  logic                              clk,
        input  logic                              rst,

        // host write port, single-cycle strobe
        input  logic                              cfg_wr_en,
        input  logic [pe_cfg_pkg::cfg_addr_w-1:0] cfg_wr_addr,
        input  logic [pe_cfg_pkg::cfg_data_w-1:0] cfg_wr_data,

        // current layer
        input  logic [pe_cfg_pkg::layer_w-1:0]    layer_idx,

        // parameters of the current layer
        output logic [pe_cfg_pkg::layer_w-1:0]    layer_no,
        output logic [act_w-1:0]                  in_act_no,
        output logic [act_w-1:0]                  out_act_no,
        output logic [col_w-1:0]                  col_dim,
        output logic [wmem_w-1:0]                 w_mem_offset,
        output logic                              in_act_relu,
        output logic                              out_act_relu,
        output logic [pe_cfg_pkg::trunc_w-1:0]    act_trunc
);

        import pe_cfg_pkg::*;

        // ---------------------------
        // decoder -> table
        // ---------------------------
        cfg_field_e                               dec_field;
        logic [layer_w-1:0]                       dec_slot;
        logic [cfg_data_w-1:0]                    dec_data;

        // ---------------------------
        // table -> selector
        // ---------------------------
        logic [layer_w-1:0]                       layer_no_q;
        logic [max_layers-1:0][act_w-1:0]         act_no_q;
        logic [param_slots-1:0][col_w-1:0]        col_dim_q;
        logic [param_slots-1:0][wmem_w-1:0]       wmem_off_q;
        logic [max_layers:0]                      relu_en_q;
        logic [param_slots-1:0][trunc_w-1:0]      trunc_q;

        cfg_write_decoder u_decoder (
                .clk     (clk),
                .rst     (rst),
                .wr_en   (cfg_wr_en),
                .wr_addr (cfg_wr_addr),
                .wr_data (cfg_wr_data),
                .field   (dec_field),
                .slot    (dec_slot),
                .data    (dec_data)
        );

        layer_param_table #(
                .act_w  (act_w),
                .col_w  (col_w),
                .wmem_w (wmem_w)
        ) u_table (
                .clk        (clk),
                .rst        (rst),
                .field      (dec_field),
                .slot       (dec_slot),
                .data       (dec_data),
                .layer_no_q (layer_no_q),
                .act_no_q   (act_no_q),
                .col_dim_q  (col_dim_q),
                .wmem_off_q (wmem_off_q),
                .relu_en_q  (relu_en_q),
                .trunc_q    (trunc_q)
        );

        layer_param_select #(
                .act_w  (act_w),
                .col_w  (col_w),
                .wmem_w (wmem_w)
        ) u_select (
                .layer_no_q   (layer_no_q),
                .act_no_q     (act_no_q),
                .col_dim_q    (col_dim_q),
                .wmem_off_q   (wmem_off_q),
                .relu_en_q    (relu_en_q),
                .trunc_q      (trunc_q),
                .layer_idx    (layer_idx),
                .layer_no     (layer_no),
                .in_act_no    (in_act_no),
                .out_act_no   (out_act_no),
                .col_dim      (col_dim),
                .w_mem_offset (w_mem_offset),
                .in_act_relu  (in_act_relu),
                .out_act_relu (out_act_relu),
                .act_trunc    (act_trunc)
        );

endmodule
